//--- source/wb_pkg.sv
package wb_pkg;

    // csr operation carried by an instruction
    typedef enum logic [1:0] {
        csr_none = 2'd0,
        csr_rd   = 2'd1,
        csr_wr   = 2'd2,
        csr_xchg = 2'd3
    } csr_op_t;

    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // implemented csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h0000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h0001;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h0005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h0006;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h000c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h0030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h0031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h0032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h0033;

    // da set, plv 0, ie 0
    localparam logic [31:0] crmd_reset = 32'h0000_0008;

    // software writable bits
    localparam logic [31:0] crmd_wmask   = 32'h0000_000f;
    localparam logic [31:0] prmd_wmask   = 32'h0000_0007;
    localparam logic [31:0] estat_wmask  = 32'h0000_0003;
    localparam logic [31:0] eentry_wmask = 32'hffff_ffc0;

    // a few exception codes
    localparam logic [ecode_w-1:0] ecode_syscall = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_break   = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine     = 6'h0d;

endpackage

//--- source/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic        rf_we,
    input  logic [4:0]  rf_waddr,
    input  logic [31:0] rf_wdata,
    input  logic [4:0]  rf_raddr1,
    input  logic [4:0]  rf_raddr2,
    output logic [31:0] rf_rdata1,
    output logic [31:0] rf_rdata2
);

    logic [31:0] regs [0:31];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (rf_we && (rf_waddr != 5'd0)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rf_rdata1 = (rf_raddr1 == 5'd0) ? 32'h0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == 5'd0) ? 32'h0 : regs[rf_raddr2];

endmodule

//--- source/csr_file.sv
module csr_file
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [csr_num_w-1:0]  csr_num,
    input  logic                  csr_we,
    input  logic [31:0]           csr_wmask,
    input  logic [31:0]           csr_wvalue,
    input  logic                  ex,
    input  logic                  ertn,
    input  logic [ecode_w-1:0]    ecode,
    input  logic [esubcode_w-1:0] esubcode,
    input  logic [31:0]           pc,
    output logic [31:0]           csr_rvalue,
    output logic [31:0]           ex_entry,
    output logic [31:0]           era_pc
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;

    // keep bits outside the combined mask
    function automatic logic [31:0] merge(input logic [31:0] old_value,
                                          input logic [31:0] reg_wmask);
        logic [31:0] m;
        m = csr_wmask & reg_wmask;
        return (old_value & ~m) | (csr_wvalue & m);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd   <= crmd_reset;
            prmd   <= 32'h0;
            estat  <= 32'h0;
            era    <= 32'h0;
            eentry <= 32'h0;
            save0  <= 32'h0;
            save1  <= 32'h0;
            save2  <= 32'h0;
            save3  <= 32'h0;
        end else begin
            if (csr_we) begin
                case (csr_num)
                    csr_crmd:   crmd   <= merge(crmd, crmd_wmask);
                    csr_prmd:   prmd   <= merge(prmd, prmd_wmask);
                    csr_estat:  estat  <= merge(estat, estat_wmask);
                    csr_era:    era    <= merge(era, 32'hffff_ffff);
                    csr_eentry: eentry <= merge(eentry, eentry_wmask);
                    csr_save0:  save0  <= merge(save0, 32'hffff_ffff);
                    csr_save1:  save1  <= merge(save1, 32'hffff_ffff);
                    csr_save2:  save2  <= merge(save2, 32'hffff_ffff);
                    csr_save3:  save3  <= merge(save3, 32'hffff_ffff);
                    default: ;
                endcase
            end

            // exception entry saves plv and ie and drops to plv0 with ie off
            if (ex) begin
                prmd[2:0]   <= crmd[2:0];
                crmd[2:0]   <= 3'b000;
                estat[21:16] <= ecode;
                estat[30:22] <= esubcode;
                era         <= pc;
            end else if (ertn) begin
                // restore plv and ie
                crmd[2:0] <= prmd[2:0];
            end
        end
    end

    always_comb begin
        case (csr_num)
            csr_crmd:   csr_rvalue = crmd;
            csr_prmd:   csr_rvalue = prmd;
            csr_estat:  csr_rvalue = estat;
            csr_era:    csr_rvalue = era;
            csr_eentry: csr_rvalue = eentry;
            csr_save0:  csr_rvalue = save0;
            csr_save1:  csr_rvalue = save1;
            csr_save2:  csr_rvalue = save2;
            csr_save3:  csr_rvalue = save3;
            // unimplemented numbers
            default:    csr_rvalue = 32'h0;
        endcase
    end

    assign ex_entry = eentry;
    assign era_pc   = era;

endmodule

//--- source/wb_stage.sv
module wb_stage
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    // from memory stage
    input  logic                  mem_valid,
    input  logic [31:0]           mem_pc,
    input  logic                  mem_rf_we,
    input  logic [4:0]            mem_rf_waddr,
    input  logic [31:0]           mem_rf_result,
    input  csr_op_t               mem_csr_op,
    input  logic [csr_num_w-1:0]  mem_csr_num,
    input  logic [31:0]           mem_csr_wvalue,
    input  logic [31:0]           mem_csr_mask,
    input  logic                  mem_ertn,
    input  logic                  mem_ex,
    input  logic [ecode_w-1:0]    mem_ecode,
    input  logic [esubcode_w-1:0] mem_esubcode,
    output logic                  wb_allowin,
    // csr file
    input  logic [31:0]           csr_rvalue,
    output logic [csr_num_w-1:0]  csr_num,
    output logic                  csr_we,
    output logic [31:0]           csr_wmask,
    output logic [31:0]           csr_wvalue,
    output logic                  csr_ex,
    output logic                  csr_ertn,
    output logic [ecode_w-1:0]    csr_ecode,
    output logic [esubcode_w-1:0] csr_esubcode,
    output logic [31:0]           wb_pc,
    // register file
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata,
    // flush and trace
    output logic                  wb_flush,
    output logic [31:0]           debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [31:0]           debug_wb_rf_wdata
);

    logic        wb_valid;
    logic        wb_rf_we_r;
    logic [31:0] wb_rf_result;
    csr_op_t     wb_csr_op;
    logic [31:0] wb_csr_mask;
    logic        wb_ertn_r;
    logic        wb_ex_r;
    logic        res_from_csr;

    // one cycle stage without back-pressure
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_pc        <= mem_pc;
            wb_rf_we_r   <= mem_rf_we;
            rf_waddr     <= mem_rf_waddr;
            wb_rf_result <= mem_rf_result;
            wb_csr_op    <= mem_csr_op;
            csr_num      <= mem_csr_num;
            csr_wvalue   <= mem_csr_wvalue;
            wb_csr_mask  <= mem_csr_mask;
            wb_ertn_r    <= mem_ertn;
            wb_ex_r      <= mem_ex;
            csr_ecode    <= mem_ecode;
            csr_esubcode <= mem_esubcode;
        end
    end

    // csr write enable and mask from the op
    assign csr_we    = wb_valid & ~wb_ex_r & ((wb_csr_op == csr_wr) | (wb_csr_op == csr_xchg));
    assign csr_wmask = (wb_csr_op == csr_xchg) ? wb_csr_mask : 32'hffff_ffff;

    assign csr_ex   = wb_valid & wb_ex_r;
    assign csr_ertn = wb_valid & wb_ertn_r;
    assign wb_flush = csr_ex | csr_ertn;

    // any csr op returns the old csr value
    assign res_from_csr = (wb_csr_op != csr_none);
    assign rf_wdata     = res_from_csr ? csr_rvalue : wb_rf_result;
    assign rf_we        = wb_valid & wb_rf_we_r & ~wb_ex_r;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- source/wb_top.sv
module wb_top
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_valid,
    input  logic [31:0]           mem_pc,
    input  logic                  mem_rf_we,
    input  logic [4:0]            mem_rf_waddr,
    input  logic [31:0]           mem_rf_result,
    input  csr_op_t               mem_csr_op,
    input  logic [csr_num_w-1:0]  mem_csr_num,
    input  logic [31:0]           mem_csr_wvalue,
    input  logic [31:0]           mem_csr_mask,
    input  logic                  mem_ertn,
    input  logic                  mem_ex,
    input  logic [ecode_w-1:0]    mem_ecode,
    input  logic [esubcode_w-1:0] mem_esubcode,
    input  logic [4:0]            rf_raddr1,
    input  logic [4:0]            rf_raddr2,
    output logic                  wb_allowin,
    output logic [31:0]           rf_rdata1,
    output logic [31:0]           rf_rdata2,
    output logic [31:0]           debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [4:0]            debug_wb_rf_wnum,
    output logic [31:0]           debug_wb_rf_wdata,
    output logic                  wb_flush,
    output logic [31:0]           ex_entry,
    output logic [31:0]           era_pc
);

    logic [31:0]           csr_rvalue;
    logic [csr_num_w-1:0]  csr_num;
    logic                  csr_we;
    logic [31:0]           csr_wmask;
    logic [31:0]           csr_wvalue;
    logic                  csr_ex;
    logic                  csr_ertn;
    logic [ecode_w-1:0]    csr_ecode;
    logic [esubcode_w-1:0] csr_esubcode;
    logic [31:0]           wb_pc;
    logic                  rf_we;
    logic [4:0]            rf_waddr;
    logic [31:0]           rf_wdata;

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_result     (mem_rf_result),
        .mem_csr_op        (mem_csr_op),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_csr_mask      (mem_csr_mask),
        .mem_ertn          (mem_ertn),
        .mem_ex            (mem_ex),
        .mem_ecode         (mem_ecode),
        .mem_esubcode      (mem_esubcode),
        .wb_allowin        (wb_allowin),
        .csr_rvalue        (csr_rvalue),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .csr_ex            (csr_ex),
        .csr_ertn          (csr_ertn),
        .csr_ecode         (csr_ecode),
        .csr_esubcode      (csr_esubcode),
        .wb_pc             (wb_pc),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_flush          (wb_flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .ex         (csr_ex),
        .ertn       (csr_ertn),
        .ecode      (csr_ecode),
        .esubcode   (csr_esubcode),
        .pc         (wb_pc),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc)
    );

    // read ports come straight from the decode side
    reg_file u_reg_file (
        .clk       (clk),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2)
    );

endmodule

//--- verification/wb_model.svh
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

// general registers and which of them are known
logic [31:0] m_regs [32];
bit          m_known [32];
// csr slots in order crmd prmd estat era eentry save0..save3
logic [31:0] m_csr [9];
logic [31:0] rng_state = 32'd48173;

// xorshift32
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic void reset_state();
    foreach (m_regs[i]) begin
        m_regs[i]  = 32'h0;
        m_known[i] = (i == 0);
    end
    foreach (m_csr[i]) begin
        m_csr[i] = 32'h0;
    end
    m_csr[0] = crmd_reset;
endfunction

function automatic int csr_slot(input logic [csr_num_w-1:0] num);
    case (num)
        csr_crmd:   return 0;
        csr_prmd:   return 1;
        csr_estat:  return 2;
        csr_era:    return 3;
        csr_eentry: return 4;
        csr_save0:  return 5;
        csr_save1:  return 6;
        csr_save2:  return 7;
        csr_save3:  return 8;
        default:    return -1;
    endcase
endfunction

function automatic logic [31:0] writable_bits(input int slot);
    case (slot)
        0:       return crmd_wmask;
        1:       return prmd_wmask;
        2:       return estat_wmask;
        4:       return eentry_wmask;
        default: return 32'hffff_ffff;
    endcase
endfunction

function automatic logic [31:0] csr_value(input logic [csr_num_w-1:0] num);
    int s;
    s = csr_slot(num);
    if (s < 0) begin
        return 32'h0;
    end
    return m_csr[s];
endfunction

// only bits allowed by both masks change
function automatic void csr_store(input logic [csr_num_w-1:0] num,
                                  input logic [31:0] value,
                                  input logic [31:0] mask);
    int          s;
    logic [31:0] m;
    s = csr_slot(num);
    if (s >= 0) begin
        m = mask & writable_bits(s);
        m_csr[s] = (m_csr[s] & ~m) | (value & m);
    end
endfunction

function automatic void enter_exception(input logic [31:0] pc,
                                        input logic [ecode_w-1:0] ecode,
                                        input logic [esubcode_w-1:0] esub);
    m_csr[1][2:0]   = m_csr[0][2:0];
    m_csr[0][2:0]   = 3'b000;
    m_csr[2][21:16] = ecode;
    m_csr[2][30:22] = esub;
    m_csr[3]        = pc;
endfunction

function automatic void return_from_exception();
    m_csr[0][2:0] = m_csr[1][2:0];
endfunction

`endif

//--- verification/wb_tb.sv
module wb_tb
    import wb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_instr    = 2000;
    localparam int max_cycles = n_instr + 50;

    logic                  clk;
    logic                  resetn;
    logic                  mem_valid;
    logic [31:0]           mem_pc;
    logic                  mem_rf_we;
    logic [4:0]            mem_rf_waddr;
    logic [31:0]           mem_rf_result;
    csr_op_t               mem_csr_op;
    logic [csr_num_w-1:0]  mem_csr_num;
    logic [31:0]           mem_csr_wvalue;
    logic [31:0]           mem_csr_mask;
    logic                  mem_ertn;
    logic                  mem_ex;
    logic [ecode_w-1:0]    mem_ecode;
    logic [esubcode_w-1:0] mem_esubcode;
    logic [4:0]            rf_raddr1;
    logic [4:0]            rf_raddr2;
    logic                  wb_allowin;
    logic [31:0]           rf_rdata1;
    logic [31:0]           rf_rdata2;
    logic [31:0]           debug_wb_pc;
    logic [3:0]            debug_wb_rf_we;
    logic [4:0]            debug_wb_rf_wnum;
    logic [31:0]           debug_wb_rf_wdata;
    logic                  wb_flush;
    logic [31:0]           ex_entry;
    logic [31:0]           era_pc;

    // instruction currently in writeback
    logic                  p_valid;
    logic [31:0]           p_pc;
    logic                  p_rf_we;
    logic [4:0]            p_waddr;
    logic [31:0]           p_result;
    csr_op_t               p_op;
    logic [csr_num_w-1:0]  p_num;
    logic [31:0]           p_wvalue;
    logic [31:0]           p_mask;
    logic                  p_ertn;
    logic                  p_ex;
    logic [ecode_w-1:0]    p_ecode;
    logic [esubcode_w-1:0] p_esub;

    int cycles = 0;

    `include "wb_model.svh"

    wb_top u_wb_top (
        .clk               (clk),
        .resetn            (resetn),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_result     (mem_rf_result),
        .mem_csr_op        (mem_csr_op),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_csr_mask      (mem_csr_mask),
        .mem_ertn          (mem_ertn),
        .mem_ex            (mem_ex),
        .mem_ecode         (mem_ecode),
        .mem_esubcode      (mem_esubcode),
        .rf_raddr1         (rf_raddr1),
        .rf_raddr2         (rf_raddr2),
        .wb_allowin        (wb_allowin),
        .rf_rdata1         (rf_rdata1),
        .rf_rdata2         (rf_rdata2),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .wb_flush          (wb_flush),
        .ex_entry          (ex_entry),
        .era_pc            (era_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // mostly implemented numbers and sometimes any number
    function automatic logic [csr_num_w-1:0] pick_csr_num(input logic [31:0] r);
        case (r % 12)
            0:       return csr_crmd;
            1:       return csr_prmd;
            2:       return csr_estat;
            3:       return csr_era;
            4:       return csr_eentry;
            5:       return csr_save0;
            6:       return csr_save1;
            7:       return csr_save2;
            8:       return csr_save3;
            default: return r[29:16];
        endcase
    endfunction

    task automatic drive_instruction();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic        ertn_sel;
        a = next_rand();
        b = next_rand();
        d = next_rand();
        ertn_sel = (a[18:13] == 6'd1);
        mem_valid      <= (a[2:0] != 3'b000);
        mem_pc         <= {b[31:2], 2'b00};
        mem_rf_waddr   <= a[7:3];
        mem_rf_we      <= (a[9:8] != 2'b00) && !ertn_sel;
        mem_rf_result  <= next_rand();
        mem_csr_op     <= (a[12] || ertn_sel) ? csr_none : csr_op_t'(a[11:10]);
        mem_csr_num    <= pick_csr_num(d);
        mem_csr_wvalue <= next_rand();
        mem_csr_mask   <= next_rand();
        mem_ex         <= (a[18:13] == 6'd0);
        mem_ertn       <= ertn_sel;
        mem_ecode      <= (a[20:19] == 2'd0) ? ecode_syscall :
                          (a[20:19] == 2'd1) ? ecode_break : ecode_ine;
        mem_esubcode   <= a[29:21];
        rf_raddr1      <= d[4:0];
        rf_raddr2      <= b[1:0] == 2'd0 ? mem_rf_waddr : d[9:5];
    endtask

    task automatic sample_read_ports();
        if (m_known[rf_raddr1]) begin
            compare_word("rf_rdata1", rf_rdata1, m_regs[rf_raddr1]);
        end
        if (m_known[rf_raddr2]) begin
            compare_word("rf_rdata2", rf_rdata2, m_regs[rf_raddr2]);
        end
    endtask

    task automatic verify_writeback();
        logic        exp_we;
        logic [31:0] exp_data;
        compare_word("wb_allowin", {31'h0, wb_allowin}, 32'h1);
        compare_word("ex_entry", ex_entry, m_csr[4]);
        compare_word("era_pc", era_pc, m_csr[3]);
        if (!p_valid) begin
            compare_word("debug_wb_rf_we on a bubble", {28'h0, debug_wb_rf_we}, 32'h0);
            compare_word("wb_flush on a bubble", {31'h0, wb_flush}, 32'h0);
        end else begin
            exp_we   = p_rf_we && !p_ex;
            exp_data = (p_op != csr_none) ? csr_value(p_num) : p_result;
            compare_word("debug_wb_pc", debug_wb_pc, p_pc);
            compare_word("debug_wb_rf_we", {28'h0, debug_wb_rf_we}, {28'h0, {4{exp_we}}});
            compare_word("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum}, {27'h0, p_waddr});
            compare_word("wb_flush", {31'h0, wb_flush}, {31'h0, p_ex || p_ertn});
            if (exp_we) begin
                compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data);
            end
        end
    endtask

    // effects land at the next edge
    task automatic retire_in_model();
        logic [31:0] wdata;
        if (p_valid && p_ex) begin
            enter_exception(p_pc, p_ecode, p_esub);
        end else if (p_valid) begin
            wdata = (p_op != csr_none) ? csr_value(p_num) : p_result;
            if (p_rf_we && p_waddr != 5'd0) begin
                m_regs[p_waddr]  = wdata;
                m_known[p_waddr] = 1'b1;
            end
            if (p_op == csr_wr) begin
                csr_store(p_num, p_wvalue, 32'hffff_ffff);
            end else if (p_op == csr_xchg) begin
                csr_store(p_num, p_wvalue, p_mask);
            end
            if (p_ertn) begin
                return_from_exception();
            end
        end
    endtask

    task automatic capture_pending();
        p_valid  = mem_valid;
        p_pc     = mem_pc;
        p_rf_we  = mem_rf_we;
        p_waddr  = mem_rf_waddr;
        p_result = mem_rf_result;
        p_op     = mem_csr_op;
        p_num    = mem_csr_num;
        p_wvalue = mem_csr_wvalue;
        p_mask   = mem_csr_mask;
        p_ertn   = mem_ertn;
        p_ex     = mem_ex;
        p_ecode  = mem_ecode;
        p_esub   = mem_esubcode;
    endtask

    initial begin
        resetn         = 1'b0;
        mem_valid      = 1'b0;
        mem_pc         = 32'h0;
        mem_rf_we      = 1'b0;
        mem_rf_waddr   = 5'd0;
        mem_rf_result  = 32'h0;
        mem_csr_op     = csr_none;
        mem_csr_num    = '0;
        mem_csr_wvalue = 32'h0;
        mem_csr_mask   = 32'h0;
        mem_ertn       = 1'b0;
        mem_ex         = 1'b0;
        mem_ecode      = '0;
        mem_esubcode   = '0;
        rf_raddr1      = 5'd0;
        rf_raddr2      = 5'd0;
        p_valid        = 1'b0;
        reset_state();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < n_instr; i++) begin
            @(posedge clk);
            drive_instruction();
            // outputs are settled by the falling edge
            @(negedge clk);
            sample_read_ports();
            verify_writeback();
            retire_in_model();
            capture_pending();
        end
        @(posedge clk);
        mem_valid <= 1'b0;
        @(negedge clk);
        sample_read_ports();
        verify_writeback();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verification
source/wb_pkg.sv
source/reg_file.sv
source/csr_file.sv
source/wb_stage.sv
source/wb_top.sv
verification/wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the writeback testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module wb_tb \
    -Mdir "$build_dir" -o wb_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/wb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
